//--- execPkg.sv
package execPkg;

	localparam int dataWidth = 16;

	// ALU operation select. Codes 9 to 15 are illegal.
	typedef logic [3:0] aluOpCode;
	localparam aluOpCode opAdd   = 4'h0;
	localparam aluOpCode opAnd   = 4'h1;
	localparam aluOpCode opOr    = 4'h2;
	localparam aluOpCode opXor   = 4'h3;
	localparam aluOpCode opSll   = 4'h4;
	localparam aluOpCode opSrl   = 4'h5;
	localparam aluOpCode opRol   = 4'h6;
	localparam aluOpCode opRor   = 4'h7;
	localparam aluOpCode opPassB = 4'h8; // Last legal code.

	typedef logic [2:0] brTypeCode;
	localparam brTypeCode brNone = 3'h0;
	localparam brTypeCode brEqz  = 3'h1;
	localparam brTypeCode brNez  = 3'h2;
	localparam brTypeCode brLtz  = 3'h3;
	localparam brTypeCode brGeqz = 3'h4;

	// Second operand source.
	typedef logic [2:0] aluSrcCode;
	localparam aluSrcCode srcSImm5 = 3'h0;
	localparam aluSrcCode srcZImm5 = 3'h1;
	localparam aluSrcCode srcSImm8 = 3'h2;
	localparam aluSrcCode srcZImm8 = 3'h3;
	localparam aluSrcCode srcReg2  = 3'h4;
	localparam aluSrcCode srcZero  = 3'h5;

	typedef logic [1:0] setCond;
	localparam setCond setEq    = 2'h0;
	localparam setCond setLt    = 2'h1;
	localparam setCond setLe    = 2'h2;
	localparam setCond setCarry = 2'h3;

	// Immediate format. imm8 is {immHi, imm5}.
	typedef struct packed {
		logic [2:0] opcode;
		setCond     cond;    // Bits 12:11.
		logic [2:0] rs;
		logic [2:0] immHi;
		logic [4:0] imm5;
	} immFormat;

	typedef struct packed {
		logic [4:0]  opcode;
		logic [10:0] disp11;
	} jmpFormat;

	typedef union packed {
		immFormat immField;
		jmpFormat jmpField;
	} instrWord;

endpackage

//--- alu.sv
`timescale 1ns/1ps

module alu (
	input  logic [execPkg::dataWidth-1:0] a,
	input  logic [execPkg::dataWidth-1:0] b,
	input  logic                          cin,
	input  logic                          invA,
	input  logic                          invB,
	input  logic                          sign,
	input  execPkg::aluOpCode             op,
	output logic [execPkg::dataWidth-1:0] result,
	output logic                          zero,
	output logic                          neg,
	output logic                          ofl
);
	import execPkg::*;

	logic [dataWidth-1:0]   aIn;
	logic [dataWidth-1:0]   bIn;
	logic [dataWidth-1:0]   sum;
	logic                   carryOut;
	logic                   signedOfl;
	logic [3:0]             shAmt;
	logic [2*dataWidth-1:0] rolWide;
	logic [2*dataWidth-1:0] rorWide;

	assign aIn = invA ? ~a : a;
	assign bIn = invB ? ~b : b;

	// Subtract is invA with cin set.
	assign {carryOut, sum} = aIn + bIn + {{(dataWidth - 1){1'b0}}, cin};

	// Same input signs, different result sign.
	assign signedOfl = (aIn[dataWidth-1] == bIn[dataWidth-1]) &&
		(sum[dataWidth-1] != aIn[dataWidth-1]);
	assign ofl = sign ? signedOfl : carryOut; // Adder flags only.

	assign shAmt = b[3:0];
	assign rolWide = {aIn, aIn} << shAmt; // Upper half is the rotate left.
	assign rorWide = {aIn, aIn} >> shAmt;

	always_comb begin
		case (op)
			opAdd:   result = sum;
			opAnd:   result = aIn & bIn;
			opOr:    result = aIn | bIn;
			opXor:   result = aIn ^ bIn;
			opSll:   result = aIn << shAmt;
			opSrl:   result = aIn >> shAmt;
			opRol:   result = rolWide[2*dataWidth-1:dataWidth];
			opRor:   result = rorWide[dataWidth-1:0];
			opPassB: result = bIn;
			default: result = '0; // Illegal op, flagged in execControl.
		endcase
	end

	assign zero = (result == '0);
	assign neg  = result[dataWidth-1];

endmodule

//--- operandSelect.sv
`timescale 1ns/1ps

module operandSelect (
	input  execPkg::instrWord             instr,
	input  logic [execPkg::dataWidth-1:0] reg2Data,
	input  execPkg::aluSrcCode            aluSrc,
	output logic [execPkg::dataWidth-1:0] bOperand
);
	import execPkg::*;

	logic [4:0] imm5;
	logic [7:0] imm8;

	assign imm5 = instr.immField.imm5;
	assign imm8 = {instr.immField.immHi, instr.immField.imm5};

	always_comb begin
		case (aluSrc)
			srcSImm5: bOperand = {{(dataWidth - 5){imm5[4]}}, imm5};
			srcZImm5: bOperand = {{(dataWidth - 5){1'b0}}, imm5};
			srcSImm8: bOperand = {{(dataWidth - 8){imm8[7]}}, imm8};
			srcZImm8: bOperand = {{(dataWidth - 8){1'b0}}, imm8};
			srcReg2:  bOperand = reg2Data;
			srcZero:  bOperand = '0;
			default:  bOperand = '0; // Codes 6 and 7.
		endcase
	end

endmodule

//--- branchTarget.sv
`timescale 1ns/1ps

module branchTarget (
	input  execPkg::instrWord             instr,
	input  logic [execPkg::dataWidth-1:0] nextPc,
	input  logic [execPkg::dataWidth-1:0] reg1Data,
	input  logic                          isReturn,
	input  logic                          pcOffSel,
	output logic [execPkg::dataWidth-1:0] targetPc
);
	import execPkg::*;

	logic [dataWidth-1:0] base;
	logic [dataWidth-1:0] disp;
	logic [10:0]          disp11;
	logic [7:0]           imm8;

	assign disp11 = instr.jmpField.disp11;
	assign imm8   = {instr.immField.immHi, instr.immField.imm5};

	assign base = isReturn ? reg1Data : nextPc; // Return goes through register 1.

	// Long jump or short branch.
	assign disp = pcOffSel ? {{(dataWidth - 11){disp11[10]}}, disp11}
		: {{(dataWidth - 8){imm8[7]}}, imm8};

	assign targetPc = base + disp; // Wraps around.

endmodule

//--- condEval.sv
`timescale 1ns/1ps

module condEval (
	input  execPkg::brTypeCode            brType,
	input  execPkg::setCond               cond,
	input  logic [execPkg::dataWidth-1:0] aluResult,
	input  logic                          zero,
	input  logic                          neg,
	input  logic                          ofl,
	output logic                          branchTaken,
	output logic [execPkg::dataWidth-1:0] setValue
);
	import execPkg::*;

	logic lessThan;
	logic setBit;

	always_comb begin
		case (brType)
			brEqz:   branchTaken = zero;
			brNez:   branchTaken = ~zero;
			brLtz:   branchTaken = neg;
			brGeqz:  branchTaken = ~neg;
			default: branchTaken = 1'b0; // brNone and illegal codes.
		endcase
	end

	// Signed compare from a subtract.
	assign lessThan = aluResult[dataWidth-1] ^ ofl;

	always_comb begin
		case (cond)
			setEq:    setBit = zero;
			setLt:    setBit = lessThan;
			setLe:    setBit = lessThan | zero;
			setCarry: setBit = ofl;
			default:  setBit = 1'b0;
		endcase
	end

	assign setValue = {{(dataWidth - 1){1'b0}}, setBit};

endmodule

//--- execControl.sv
`timescale 1ns/1ps

module execControl (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          flush,
	input  logic                          halt,
	input  logic                          regWrt,
	input  logic                          memWrt,
	input  logic                          memEn,
	input  execPkg::aluSrcCode            aluSrc,
	input  execPkg::brTypeCode            brType,
	input  execPkg::aluOpCode             aluOp,
	input  logic [2:0]                    writeReg,
	input  logic [2:0]                    regWrtSrc,
	input  logic [execPkg::dataWidth-1:0] aluResult,
	input  logic [execPkg::dataWidth-1:0] setValue,
	input  logic [execPkg::dataWidth-1:0] targetPc,
	input  logic [execPkg::dataWidth-1:0] reg2Data,
	input  logic [execPkg::dataWidth-1:0] nextPc,
	input  logic                          branchTaken,
	output logic [execPkg::dataWidth-1:0] aluOut,
	output logic [execPkg::dataWidth-1:0] setVal,
	output logic [execPkg::dataWidth-1:0] jumpPc,
	output logic [execPkg::dataWidth-1:0] reg2DataOut,
	output logic [execPkg::dataWidth-1:0] nextPcOut,
	output logic                          doBranch,
	output logic                          regWrtOut,
	output logic                          memWrtOut,
	output logic                          memEnOut,
	output logic                          haltOut,
	output logic                          err,
	output logic [2:0]                    writeRegOut,
	output logic [2:0]                    regWrtSrcOut
);
	import execPkg::*;

	logic badCode;

	// Legal codes are packed from zero upward.
	assign badCode = (aluSrc > srcZero) | (brType > brGeqz) | (aluOp > opPassB);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			aluOut       <= '0;
			setVal       <= '0;
			jumpPc       <= '0;
			reg2DataOut  <= '0;
			nextPcOut    <= '0;
			writeRegOut  <= '0;
			regWrtSrcOut <= '0;
			doBranch     <= 1'b0;
			regWrtOut    <= 1'b0;
			memWrtOut    <= 1'b0;
			memEnOut     <= 1'b0;
			haltOut      <= 1'b0;
			err          <= 1'b0;
		end else begin
			aluOut       <= aluResult;
			setVal       <= setValue;
			jumpPc       <= targetPc;
			reg2DataOut  <= reg2Data;
			nextPcOut    <= nextPc;
			writeRegOut  <= writeReg;
			regWrtSrcOut <= regWrtSrc;
			err          <= badCode;
			// Flush squashes side effects only.
			doBranch     <= branchTaken & ~flush;
			regWrtOut    <= regWrt & ~flush;
			memWrtOut    <= memWrt & ~flush;
			memEnOut     <= memEn & ~flush;
			haltOut      <= halt & ~flush;
		end
	end

	// A store from decode must come with the memory enable.
	memWrtNeedsEn: assert property (@(posedge clk) disable iff (!rstN)
		memWrtOut |-> memEnOut)
		else $error("execControl: memWrtOut without memEnOut");

endmodule

//--- executeStage.sv
`timescale 1ns/1ps

module executeStage (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          flush,
	input  logic                          halt,
	input  logic                          regWrt,
	input  logic                          memWrt,
	input  logic                          memEn,
	input  execPkg::aluSrcCode            aluSrc,
	input  execPkg::brTypeCode            brType,
	input  execPkg::aluOpCode             aluOp,
	input  logic [2:0]                    writeReg,
	input  logic [2:0]                    regWrtSrc,
	input  execPkg::instrWord             instr,
	input  logic [execPkg::dataWidth-1:0] reg1Data,
	input  logic [execPkg::dataWidth-1:0] reg2Data,
	input  logic [execPkg::dataWidth-1:0] nextPc,
	input  logic                          invA,
	input  logic                          invB,
	input  logic                          cin,
	input  logic                          sign,
	input  logic                          isReturn,
	input  logic                          pcOffSel,
	output logic [execPkg::dataWidth-1:0] aluOut,
	output logic [execPkg::dataWidth-1:0] setVal,
	output logic [execPkg::dataWidth-1:0] jumpPc,
	output logic [execPkg::dataWidth-1:0] reg2DataOut,
	output logic [execPkg::dataWidth-1:0] nextPcOut,
	output logic                          doBranch,
	output logic                          regWrtOut,
	output logic                          memWrtOut,
	output logic                          memEnOut,
	output logic                          haltOut,
	output logic                          err,
	output logic [2:0]                    writeRegOut,
	output logic [2:0]                    regWrtSrcOut
);
	import execPkg::*;

	logic [dataWidth-1:0] bOperand;
	logic [dataWidth-1:0] aluResult;
	logic [dataWidth-1:0] setValue;
	logic [dataWidth-1:0] targetPc;
	logic                 zero;
	logic                 neg;
	logic                 ofl;
	logic                 branchTaken;

	operandSelect opSel0 (.instr(instr), .reg2Data(reg2Data), .aluSrc(aluSrc),
		.bOperand(bOperand));

	alu alu0 (.a(reg1Data), .b(bOperand), .cin(cin), .invA(invA), .invB(invB),
		.sign(sign), .op(aluOp), .result(aluResult), .zero(zero), .neg(neg), .ofl(ofl));

	branchTarget brTgt0 (.instr(instr), .nextPc(nextPc), .reg1Data(reg1Data),
		.isReturn(isReturn), .pcOffSel(pcOffSel), .targetPc(targetPc));

	// Set condition comes from bits 12:11.
	condEval cond0 (.brType(brType), .cond(instr.immField.cond), .aluResult(aluResult),
		.zero(zero), .neg(neg), .ofl(ofl), .branchTaken(branchTaken), .setValue(setValue));

	execControl ctrl0 (.clk(clk), .rstN(rstN), .flush(flush), .halt(halt),
		.regWrt(regWrt), .memWrt(memWrt), .memEn(memEn), .aluSrc(aluSrc),
		.brType(brType), .aluOp(aluOp), .writeReg(writeReg), .regWrtSrc(regWrtSrc),
		.aluResult(aluResult), .setValue(setValue), .targetPc(targetPc),
		.reg2Data(reg2Data), .nextPc(nextPc), .branchTaken(branchTaken),
		.aluOut(aluOut), .setVal(setVal), .jumpPc(jumpPc), .reg2DataOut(reg2DataOut),
		.nextPcOut(nextPcOut), .doBranch(doBranch), .regWrtOut(regWrtOut),
		.memWrtOut(memWrtOut), .memEnOut(memEnOut), .haltOut(haltOut), .err(err),
		.writeRegOut(writeRegOut), .regWrtSrcOut(regWrtSrcOut));

endmodule

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic clk,
	output logic rstN
);
	localparam int halfPeriod = 20; // 40 ns clock.
	localparam int resetCycles = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		rstN <= 1'b1; // Released after the fourth edge.
	end

endmodule

//--- executeStage_tb.sv
`timescale 1ns/1ps

module executeStage_tb;
	import execPkg::*;

	localparam int inW = 91;  // All DUT inputs of one vector.
	localparam int expW = 51; // aluOut, setVal, jumpPc, doBranch, err, regWrtOut.
	localparam int randCount = 20;

	logic clk, rstN;
	logic flush, halt, regWrt, memWrt, memEn;
	aluSrcCode aluSrc;
	brTypeCode brType;
	aluOpCode aluOp;
	logic [2:0] writeReg, regWrtSrc;
	instrWord instr;
	logic [15:0] reg1Data, reg2Data, nextPc;
	logic invA, invB, cin, sign, isReturn, pcOffSel;
	logic [15:0] aluOut, setVal, jumpPc, reg2DataOut, nextPcOut;
	logic doBranch, regWrtOut, memWrtOut, memEnOut, haltOut, err;
	logic [2:0] writeRegOut, regWrtSrcOut;

	logic [inW-1:0] inQ[$];
	logic [expW-1:0] expQ[$];
	int errors;
	int numVec;
	logic loaded;
	logic [31:0] rnd;

	tbClock clkGen (.clk(clk), .rstN(rstN));

	executeStage dut0 (.*);

	task automatic loadVectors();
		int fd;
		logic fl, ha, rw, mw, me, iA, iB, ci, sg, rt, po, eB, eE, eR;
		logic [2:0] src, br, wr, rws;
		logic [3:0] op;
		logic [15:0] ins, r1, r2, np, eA, eS, eJ;
		fd = $fopen("exec_tests.txt", "r");
		if (fd == 0) begin
			$display("Could not open exec_tests.txt, no fixed vectors were run");
			errors++;
		end else begin
			while ($fscanf(fd, "%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h%h",
				fl, ha, rw, mw, me, src, br, op, wr, rws, ins, r1, r2, np,
				iA, iB, ci, sg, rt, po, eA, eS, eJ, eB, eE, eR) == 26) begin
				inQ.push_back({fl, ha, rw, mw, me, src, br, op, wr, rws, ins, r1, r2, np,
					iA, iB, ci, sg, rt, po});
				expQ.push_back({eA, eS, eJ, eB, eE, eR});
			end
			$fclose(fd);
			if (inQ.size() == 0) begin
				$display("No vectors could be read from exec_tests.txt");
				errors++;
			end
		end
	endtask

	task automatic addRandomVectors();
		logic [15:0] a, b, s, np;
		logic [31:0] ctl;
		logic [2:0] wr, rws;
		logic ha, me, mw;
		for (int k = 0; k < randCount; k++) begin
			rnd = $urandom;
			ctl = $urandom;
			a = rnd[15:0];
			b = rnd[31:16];
			np = ctl[15:0];
			wr = ctl[18:16];
			rws = ctl[21:19];
			ha = ctl[22];
			me = ctl[23];
			mw = ctl[24] & ctl[23]; // A store always has the enable.
			s = a + b; // Carry dropped.
			// Register add, no branch, set on equal shows the zero flag.
			inQ.push_back({1'b0, ha, 1'b1, mw, me, srcReg2, brNone, opAdd, wr, rws, 16'h0000,
				a, b, np, 6'b0});
			expQ.push_back({s, 15'b0, (s == 16'h0000), np, 3'b001});
		end
	endtask

	task automatic checkField(input string tag, input string name, input logic [15:0] expV,
		input logic [15:0] actV);
		if (actV !== expV) begin
			$display("FAILED at %0t ns: %s %s expected %h, got %h", $time, tag, name, expV,
				actV);
			errors++;
		end
	endtask

	task automatic checkVector(input int idx);
		string tag;
		logic [15:0] eAlu, eSet, eJmp;
		logic eBr, eErr, eRw;
		logic [inW-1:0] vec;
		logic fl, ha, mw, me;
		logic [2:0] wr, rws;
		logic [15:0] r2, np;
		logic [2:0] eSide;
		tag = $sformatf("vector %0d", idx);
		{eAlu, eSet, eJmp, eBr, eErr, eRw} = expQ[idx];
		vec = inQ[idx];
		fl = vec[90];
		ha = vec[89];
		mw = vec[87];
		me = vec[86];
		wr = vec[75:73];
		rws = vec[72:70];
		r2 = vec[37:22];
		np = vec[21:6];
		checkField(tag, "aluOut", eAlu, aluOut);
		checkField(tag, "setVal", eSet, setVal);
		checkField(tag, "jumpPc", eJmp, jumpPc);
		checkField(tag, "doBranch", {15'b0, eBr}, {15'b0, doBranch});
		checkField(tag, "err", {15'b0, eErr}, {15'b0, err});
		checkField(tag, "regWrtOut", {15'b0, eRw}, {15'b0, regWrtOut});
		// Pass-through fields.
		checkField(tag, "reg2DataOut", r2, reg2DataOut);
		checkField(tag, "nextPcOut", np, nextPcOut);
		checkField(tag, "writeRegOut", {13'b0, wr}, {13'b0, writeRegOut});
		checkField(tag, "regWrtSrcOut", {13'b0, rws}, {13'b0, regWrtSrcOut});
		if (fl) begin
			eSide = 3'b000; // Squashed by flush.
		end else begin
			eSide = {mw, me, ha};
		end
		checkField(tag, "memWrtOut/memEnOut/haltOut", {13'b0, eSide},
			{13'b0, memWrtOut, memEnOut, haltOut});
	endtask

	initial begin
		errors = 0;
		loaded = 1'b0;
		{flush, halt, regWrt, memWrt, memEn, aluSrc, brType, aluOp, writeReg, regWrtSrc,
			instr, reg1Data, reg2Data, nextPc, invA, invB, cin, sign, isReturn,
			pcOffSel} = '0;
		halt = 1'b1;   // Held during reset.
		regWrt = 1'b1;
		memWrt = 1'b1;
		memEn = 1'b1;
		aluSrc = 3'd7;  // Illegal source would raise err.
		reg1Data = 16'h1234;
		rnd = $urandom(82169);
		loadVectors();
		addRandomVectors();
		numVec = inQ.size();
		loaded = 1'b1;

		wait (rstN === 1'b1);
		@(negedge clk);
		checkField("reset", "control bits", 16'h0000,
			{10'b0, doBranch, regWrtOut, memWrtOut, memEnOut, haltOut, err});
		checkField("reset", "aluOut", 16'h0000, aluOut);

		// One vector per edge, each checked after the next edge.
		for (int i = 0; i <= numVec; i++) begin
			@(posedge clk);
			if (i < numVec) begin
				{flush, halt, regWrt, memWrt, memEn, aluSrc, brType, aluOp, writeReg,
					regWrtSrc, instr, reg1Data, reg2Data, nextPc, invA, invB, cin, sign,
					isReturn, pcOffSel} <= inQ[i];
			end
			@(negedge clk);
			if (i > 0) checkVector(i - 1);
		end

		$display("Checked %0d vectors, %0d errors", numVec, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		wait (loaded);
		#((numVec + 30) * 40);
		$display("Timeout: the run did not finish within %0d cycles", numVec + 30);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

//--- exec_tests.txt
0 0 1 0 0 4 0 0 1 0 0000 0005 0003 0100 0 0 0 0 0 0 0008 0000 0100 0 0 1
0 0 1 0 0 4 0 0 1 0 0800 0003 0005 0100 1 0 1 1 0 0 0002 0000 0100 0 0 1
0 0 1 0 0 4 0 0 1 0 0800 0005 0003 0100 1 0 1 1 0 0 FFFE 0001 0100 0 0 1
0 0 1 0 0 4 0 0 1 0 0800 0001 8000 0100 1 0 1 1 0 0 7FFF 0001 0100 0 0 1
0 0 1 0 0 4 0 0 1 0 1000 0004 0004 0100 1 0 1 1 0 0 0000 0001 0100 0 0 1
0 0 1 0 0 4 1 0 1 0 1800 FFFF 0001 0100 0 0 0 0 0 0 0000 0001 0100 1 0 1
0 0 1 0 0 0 0 0 1 0 001F 0010 0000 0100 0 0 0 0 0 0 000F 0000 011F 0 0 1
0 0 1 0 0 1 0 0 1 0 001F 0010 0000 0100 0 0 0 0 0 0 002F 0000 011F 0 0 1
0 0 1 0 0 2 0 0 1 0 00F0 0020 0000 0100 0 0 0 0 0 0 0010 0000 00F0 0 0 1
0 0 1 0 0 3 0 0 1 0 00F0 0020 0000 0100 0 0 0 0 0 0 0110 0000 00F0 0 0 1
0 0 1 0 0 5 2 8 1 0 0000 1234 0000 0100 0 0 0 0 0 0 0000 0001 0100 0 0 1
0 0 1 0 0 4 2 1 1 0 0000 F0F0 3C3C 0100 0 0 0 0 0 0 3030 0000 0100 1 0 1
0 0 1 0 0 4 3 2 1 0 0000 F0F0 3C3C 0100 0 0 0 0 0 0 FCFC 0000 0100 1 0 1
0 0 1 0 0 4 4 3 1 0 0000 F0F0 3C3C 0100 0 0 0 0 0 0 CCCC 0000 0100 0 0 1
0 0 1 0 0 1 4 4 1 0 0004 1234 0000 0100 0 0 0 0 0 0 2340 0000 0104 1 0 1
0 0 1 0 0 1 0 5 1 0 0004 1234 0000 0100 0 0 0 0 0 0 0123 0000 0104 0 0 1
0 0 1 0 0 1 0 6 1 0 0004 1234 0000 0100 0 0 0 0 0 0 2341 0000 0104 0 0 1
0 0 1 0 0 1 0 7 1 0 0004 1234 0000 0100 0 0 0 0 0 0 4123 0000 0104 0 0 1
0 0 1 0 0 5 1 0 1 0 0400 0000 0000 1000 0 0 0 0 0 1 0000 0001 0C00 1 0 1
0 0 1 0 0 5 0 0 1 0 03FF 0000 0000 1000 0 0 0 0 0 1 0000 0001 13FF 0 0 1
0 0 1 0 0 5 0 0 1 0 0002 2000 0000 0100 0 0 0 0 1 0 2000 0000 2002 0 0 1
0 0 1 0 0 6 0 0 1 0 0000 0007 0000 0100 0 0 0 0 0 0 0007 0000 0100 0 1 1
0 0 1 0 0 4 5 0 1 0 0000 0000 0000 0100 0 0 0 0 0 0 0000 0001 0100 0 1 1
0 0 1 0 0 4 0 9 1 0 0000 0001 0001 0100 0 0 0 0 0 0 0000 0001 0100 0 1 1
1 1 1 1 1 4 2 0 1 0 0000 0005 0003 0100 0 0 0 0 0 0 0008 0000 0100 0 0 0
0 0 1 0 0 4 2 0 1 0 0000 0005 0004 0100 0 0 0 0 0 0 0009 0000 0100 1 0 1

//--- sim.f
execPkg.sv
alu.sv
operandSelect.sv
branchTarget.sv
condEval.sv
execControl.sv
executeStage.sv
tbClock.sv
executeStage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator.

verilator --binary --timing -Wno-fatal -f sim.f --top-module executeStage_tb -o simv
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
	exit 0
fi
exit 1
